/* compile.f */
+incdir+design
design/fpu_in_pkg.sv
design/fpu_req_decode.sv
design/fpu_tag_queue.sv
design/fpu_issue_ctl.sv
design/fpu_in_top.sv
tb/tb_fpu_in.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_fpu_in
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "sim passed" $(LOG); then echo "FAIL: run did not complete"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD) $(LOG)

/* tb/tb_fpu_in.sv */
/*
 * testbench for the fpu input control
 * directed tests of request decode, tag queues, issue and pipe
 * clock enables, checked against a reference model of both queues
 */

`timescale 1ns/1ps

module tb_fpu_in;

        logic           i_rclk;
        logic           i_rst_n;
        logic           i_req_rdy;
        logic           i_req_vld;
        logic [4:0]     i_req_type;
        logic [1:0]     i_req_op;
        logic           i_req_op7;
        logic           i_add_step;
        logic           i_mul_step;
        logic           i_div_step;
        logic           i_add_active;
        logic           i_mul_active;
        logic           i_div_active;
        logic           o_add;
        logic           o_mul;
        logic           o_div;
        logic           o_fadd_clken_l;
        logic           o_fmul_clken_l;
        logic           o_fdiv_clken_l;

        logic [2:0]     am_q[$];        // expected add/mul queue with the head first
        logic [2:0]     div_q[$];
        integer         errors;
        integer         failed_tests;
        integer         test_count;
        integer         seed;

        fpu_in_top dut_i (.*);

        initial begin
                i_rclk = 1'b0;
                forever #10 i_rclk = ~i_rclk;
        end

        //////////////////////////////
        // helpers
        //////////////////////////////

        // expected tag from the classification table or zero for an ignored request
        function automatic logic [2:0] classify(input logic rdy, input logic vld,
                        input logic [4:0] typ, input logic [1:0] op, input logic op7);
                logic [2:0] tag;
                tag = 3'b000;
                if (rdy && vld && typ == 5'h0a && op7) begin
                        tag = 3'b001;
                end else if (rdy && vld && typ == 5'h0b && !op7) begin
                        case (op)
                                2'b10:   tag = 3'b010;
                                2'b11:   tag = 3'b100;
                                default: tag = 3'b001;  // opcode bit 3 clear
                        endcase
                end
                return tag;
        endfunction

        function automatic logic pipe_clken(input logic div_pipe);
                return div_pipe ? o_fdiv_clken_l : o_fmul_clken_l;
        endfunction

        task automatic next_cycle();
                @(posedge i_rclk);
                #2;                     // outputs settled and inputs driven here
        endtask

        task automatic expect_bit(input string name, input logic exp, input logic act);
                if (act !== exp) begin
                        $display("error at %0t: %s expected %b got %b", $time, name, exp, act);
                        errors++;
                end
        endtask

        // compares the shown tags with the model queue heads
        task automatic check_tags();
                logic [2:0] am_head;
                am_head = (am_q.size() > 0) ? am_q[0] : 3'b000;
                expect_bit("o_add", am_head[0], o_add);
                expect_bit("o_mul", am_head[1], o_mul);
                expect_bit("o_div", div_q.size() > 0, o_div);
        endtask

        // one request cycle that returns just after the sampling edge
        task automatic send_req(input logic rdy, input logic vld, input logic [4:0] typ,
                        input logic [1:0] op, input logic op7);
                logic [2:0] tag;
                tag = classify(rdy, vld, typ, op, op7);
                if (tag[2]) begin
                        div_q.push_back(tag);
                end else if (tag != 3'b000) begin
                        am_q.push_back(tag);
                end
                i_req_rdy  = rdy;
                i_req_vld  = vld;
                i_req_type = typ;
                i_req_op   = op;
                i_req_op7  = op7;
                next_cycle();
                i_req_rdy = 1'b1;
                i_req_vld = 1'b0;
        endtask

        task automatic pulse_step(input logic add, input logic mul, input logic div);
                if (am_q.size() > 0 && ((add && am_q[0] == 3'b001) ||
                                (mul && am_q[0] == 3'b010))) begin
                        am_q.delete(0);
                end
                if (div && div_q.size() > 0) begin
                        div_q.delete(0);
                end
                i_add_step = add;
                i_mul_step = mul;
                i_div_step = div;
                next_cycle();
                i_add_step = 1'b0;
                i_mul_step = 1'b0;
                i_div_step = 1'b0;
        endtask

        task automatic report_test(input string name, input integer errs_before);
                test_count++;
                if (errors == errs_before) begin
                        $display("test %s: ok", name);
                end else begin
                        failed_tests++;
                        $display("test %s: %0d errors", name, errors - errs_before);
                end
        endtask

        //////////////////////////////
        // tests
        //////////////////////////////

        task automatic reset_state();
                integer start;
                start = errors;
                repeat (8) begin
                        next_cycle();
                        expect_bit("o_fadd_clken_l", 1'b0, o_fadd_clken_l);
                        expect_bit("o_fmul_clken_l", 1'b0, o_fmul_clken_l);
                        expect_bit("o_fdiv_clken_l", 1'b0, o_fdiv_clken_l);
                end
                i_rst_n = 1'b1;
                check_tags();
                next_cycle();
                expect_bit("o_fadd_clken_l", 1'b1, o_fadd_clken_l);
                expect_bit("o_fmul_clken_l", 1'b1, o_fmul_clken_l);
                expect_bit("o_fdiv_clken_l", 1'b1, o_fdiv_clken_l);
                report_test("reset_state", start);
        endtask

        task automatic add_classify();
                integer start;
                start = errors;
                for (int i = 0; i < 2; i++) begin
                        if (i == 0) begin
                                send_req(1'b1, 1'b1, 5'h0a, 2'b00, 1'b1);
                        end else begin
                                send_req(1'b1, 1'b1, 5'h0b, 2'b01, 1'b0);
                        end
                        expect_bit("o_add", 1'b0, o_add);       // still in decode
                        expect_bit("o_fadd_clken_l", 1'b1, o_fadd_clken_l);
                        next_cycle();
                        check_tags();
                        expect_bit("o_fadd_clken_l", 1'b0, o_fadd_clken_l);
                        pulse_step(1'b1, 1'b0, 1'b0);
                        check_tags();
                        expect_bit("o_fadd_clken_l", 1'b0, o_fadd_clken_l);  // one cycle after the tag
                end
                report_test("add_classify", start);
        endtask

        task automatic order_and_backpressure();
                integer start;
                start = errors;
                send_req(1'b1, 1'b1, 5'h0b, 2'b00, 1'b0);
                send_req(1'b1, 1'b1, 5'h0b, 2'b11, 1'b0);
                send_req(1'b1, 1'b1, 5'h0b, 2'b10, 1'b0);
                repeat (3) begin
                        check_tags();           // add held with no step
                        next_cycle();
                end
                pulse_step(1'b0, 1'b0, 1'b1);   // divide goes alone
                check_tags();
                pulse_step(1'b1, 1'b0, 1'b0);
                check_tags();
                pulse_step(1'b0, 1'b1, 1'b0);
                check_tags();
                report_test("order_and_backpressure", start);
        endtask

        task automatic ignored_requests();
                integer start;
                start = errors;
                send_req(1'b0, 1'b1, 5'h0b, 2'b00, 1'b0);
                check_tags();
                send_req(1'b1, 1'b0, 5'h0b, 2'b10, 1'b0);
                check_tags();
                send_req(1'b1, 1'b1, 5'h05, 2'b11, 1'b0);
                check_tags();
                send_req(1'b1, 1'b1, 5'h0a, 2'b00, 1'b0);
                repeat (3) begin
                        check_tags();
                        next_cycle();
                end
                report_test("ignored_requests", start);
        endtask

        task automatic pipe_clock_enable(input logic div_pipe);
                integer start;
                string name;
                start = errors;
                name = div_pipe ? "o_fdiv_clken_l" : "o_fmul_clken_l";
                i_mul_active = !div_pipe;
                i_div_active = div_pipe;
                next_cycle();
                expect_bit(name, 1'b0, pipe_clken(div_pipe));
                i_mul_active = 1'b0;
                i_div_active = 1'b0;
                next_cycle();
                expect_bit(name, 1'b1, pipe_clken(div_pipe));
                send_req(1'b1, 1'b1, 5'h0b, div_pipe ? 2'b11 : 2'b10, 1'b0);
                expect_bit(name, 1'b1, pipe_clken(div_pipe));   // tag not shown yet
                repeat (2) begin
                        next_cycle();
                        expect_bit(name, 1'b0, pipe_clken(div_pipe));
                end
                pulse_step(1'b0, !div_pipe, div_pipe);
                expect_bit(name, 1'b0, pipe_clken(div_pipe));   // one cycle after the tag
                next_cycle();
                expect_bit(name, 1'b1, pipe_clken(div_pipe));
                check_tags();
                report_test(div_pipe ? "div_clock_enable" : "mul_clock_enable", start);
        endtask

        task automatic random_order();
                integer start;
                integer cycles;
                logic [31:0] r;
                start = errors;
                for (int n = 0; n < 8; n++) begin
                        r = $random(seed);
                        if (r[0]) begin
                                send_req(1'b1, 1'b1, 5'h0b, 2'b10, 1'b0);
                        end else if (r[1]) begin
                                send_req(1'b1, 1'b1, 5'h0a, r[3:2], 1'b1);
                        end else begin
                                send_req(1'b1, 1'b1, 5'h0b, {1'b0, r[2]}, 1'b0);
                        end
                        if (r[4]) begin
                                send_req(1'b1, 1'b1, 5'h0b, 2'b11, 1'b0);
                        end
                end
                next_cycle();                   // last write lands
                cycles = 0;
                while ((am_q.size() > 0 || div_q.size() > 0) && cycles < 200) begin
                        check_tags();
                        r = $random(seed);
                        pulse_step(r[0], r[1], r[2]);
                        cycles++;
                end
                if (am_q.size() > 0 || div_q.size() > 0) begin
                        $display("timeout: tag queues not drained after %0d cycles", cycles);
                        errors++;
                end
                check_tags();
                report_test("random_order", start);
        endtask

        initial begin
                seed         = 16791;
                errors       = 0;
                failed_tests = 0;
                test_count   = 0;
                i_rst_n      = 1'b0;
                i_req_rdy    = 1'b1;
                i_req_vld    = 1'b0;
                i_req_type   = 5'h00;
                i_req_op     = 2'b00;
                i_req_op7    = 1'b0;
                i_add_step   = 1'b0;
                i_mul_step   = 1'b0;
                i_div_step   = 1'b0;
                i_add_active = 1'b0;
                i_mul_active = 1'b0;
                i_div_active = 1'b0;

                reset_state();
                add_classify();
                order_and_backpressure();
                ignored_requests();
                pipe_clock_enable(1'b0);
                pipe_clock_enable(1'b1);
                random_order();

                $display("tests %0d, failed %0d, errors %0d", test_count, failed_tests, errors);
                if (failed_tests == 0 && errors == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

/* design/fpu_in_top.sv */
/*
 * fpu input control top
 * request decode feeding an add/multiply tag queue and a divide
 * tag queue, followed by the issue stage toward the fp pipes
 */

`timescale 1ns/1ps

module fpu_in_top (
        input  logic                    i_rclk,
        input  logic                    i_rst_n,
        input  logic                    i_req_rdy,
        input  logic                    i_req_vld,
        input  fpu_in_pkg::req_type_t   i_req_type,
        input  fpu_in_pkg::fp_op_t      i_req_op,
        input  logic                    i_req_op7,
        input  logic                    i_add_step,
        input  logic                    i_mul_step,
        input  logic                    i_div_step,
        input  logic                    i_add_active,
        input  logic                    i_mul_active,
        input  logic                    i_div_active,
        output logic                    o_add,
        output logic                    o_mul,
        output logic                    o_div,
        output logic                    o_fadd_clken_l,
        output logic                    o_fmul_clken_l,
        output logic                    o_fdiv_clken_l
);

        import fpu_in_pkg::*;

        logic           am_we;
        logic           div_we;
        pipe_tag_t      wr_tag;         // same tag goes to both queues
        pipe_tag_t      am_head;
        logic           am_empty;
        logic           am_pop;
        pipe_tag_t      div_head;
        logic           div_empty;
        logic           div_pop;

        //////////////////////////////
        // decode stage
        //////////////////////////////

        fpu_req_decode decode_i (
                .i_rclk         (i_rclk),
                .i_rst_n        (i_rst_n),
                .i_req_rdy      (i_req_rdy),
                .i_req_vld      (i_req_vld),
                .i_req_type     (i_req_type),
                .i_req_op       (i_req_op),
                .i_req_op7      (i_req_op7),
                .o_am_we        (am_we),
                .o_div_we       (div_we),
                .o_tag          (wr_tag)
        );

        //////////////////////////////
        // queue stage
        //////////////////////////////

        fpu_tag_queue am_queue_i (
                .i_rclk         (i_rclk),
                .i_rst_n        (i_rst_n),
                .i_we           (am_we),
                .i_tag          (wr_tag),
                .i_pop          (am_pop),
                .o_head         (am_head),
                .o_empty        (am_empty)
        );

        fpu_tag_queue div_queue_i (
                .i_rclk         (i_rclk),
                .i_rst_n        (i_rst_n),
                .i_we           (div_we),
                .i_tag          (wr_tag),
                .i_pop          (div_pop),
                .o_head         (div_head),
                .o_empty        (div_empty)
        );

        //////////////////////////////
        // issue stage
        //////////////////////////////

        fpu_issue_ctl issue_i (
                .i_rclk         (i_rclk),
                .i_rst_n        (i_rst_n),
                .i_am_head      (am_head),
                .i_am_empty     (am_empty),
                .i_div_head     (div_head),
                .i_div_empty    (div_empty),
                .i_add_step     (i_add_step),
                .i_mul_step     (i_mul_step),
                .i_div_step     (i_div_step),
                .i_add_active   (i_add_active),
                .i_mul_active   (i_mul_active),
                .i_div_active   (i_div_active),
                .o_add          (o_add),
                .o_mul          (o_mul),
                .o_div          (o_div),
                .o_am_pop       (am_pop),
                .o_div_pop      (div_pop),
                .o_fadd_clken_l (o_fadd_clken_l),
                .o_fmul_clken_l (o_fmul_clken_l),
                .o_fdiv_clken_l (o_fdiv_clken_l)
        );

endmodule

/* design/fpu_issue_ctl.sv */
/*
 * fpu issue control
 * presents the head tags to the add, multiply and divide pipes,
 * pops a queue when its pipe takes the tag and derives the
 * per-pipe clock enables (active low)
 */

`timescale 1ns/1ps

module fpu_issue_ctl (
        input  logic                    i_rclk,
        input  logic                    i_rst_n,
        input  fpu_in_pkg::pipe_tag_t   i_am_head,
        input  logic                    i_am_empty,
        input  fpu_in_pkg::pipe_tag_t   i_div_head,
        input  logic                    i_div_empty,
        input  logic                    i_add_step,     // add pipe load
        input  logic                    i_mul_step,     // mul pipe load
        input  logic                    i_div_step,     // div pipe load
        input  logic                    i_add_active,
        input  logic                    i_mul_active,
        input  logic                    i_div_active,
        output logic                    o_add,
        output logic                    o_mul,
        output logic                    o_div,
        output logic                    o_am_pop,
        output logic                    o_div_pop,
        output logic                    o_fadd_clken_l,
        output logic                    o_fmul_clken_l,
        output logic                    o_fdiv_clken_l
);

        logic   add_dly;
        logic   mul_dly;
        logic   div_dly;

        //////////////////////////////
        // tag presentation
        //////////////////////////////

        assign o_add = !i_am_empty && i_am_head[0];
        assign o_mul = !i_am_empty && i_am_head[1];
        assign o_div = !i_div_empty && i_div_head[2];

        // the head leaves when the pipe it targets steps
        assign o_am_pop  = (o_add && i_add_step) || (o_mul && i_mul_step);
        assign o_div_pop = o_div && i_div_step;

        //////////////////////////////
        // pipe clock enables
        //////////////////////////////

        always_ff @(posedge i_rclk) begin
                if (!i_rst_n) begin
                        add_dly <= 1'b0;
                        mul_dly <= 1'b0;
                        div_dly <= 1'b0;
                end else begin
                        add_dly <= o_add;
                        mul_dly <= o_mul;
                        div_dly <= o_div;
                end
        end

        // clocks keep running through reset and one cycle past a tag
        assign o_fadd_clken_l = !(i_add_active || o_add || add_dly || !i_rst_n);
        assign o_fmul_clken_l = !(i_mul_active || o_mul || mul_dly || !i_rst_n);
        assign o_fdiv_clken_l = !(i_div_active || o_div || div_dly || !i_rst_n);

        // one shared queue head can only target one of the two pipes
        a_am_exclusive: assert property (@(posedge i_rclk) disable iff (!i_rst_n)
                !(o_add && o_mul));

endmodule

/* design/fpu_tag_queue.sv */
/*
 * pipe tag queue
 * circular store of one-hot pipe tags with wrap-bit pointers,
 * shows the head tag and tracks empty and full
 */

`timescale 1ns/1ps

`include "fpu_in_defines.svh"

module fpu_tag_queue (
        input  logic                    i_rclk,
        input  logic                    i_rst_n,
        input  logic                    i_we,
        input  fpu_in_pkg::pipe_tag_t   i_tag,
        input  logic                    i_pop,
        output fpu_in_pkg::pipe_tag_t   o_head,
        output logic                    o_empty
);

        import fpu_in_pkg::*;

        pipe_tag_t      mem [`FPU_INQ_DEPTH];
        inq_ptr_t       wr_ptr;
        inq_ptr_t       rd_ptr;
        logic           full;
        logic           do_wr;
        logic           do_rd;

        //////////////////////////////
        // status
        //////////////////////////////

        assign o_empty = (wr_ptr == rd_ptr);
        // same index, opposite lap
        assign full    = ((wr_ptr ^ rd_ptr) == {1'b1, {`FPU_INQ_PTR_W{1'b0}}});

        assign do_wr = i_we && !full;   // an overflow write is dropped
        assign do_rd = i_pop && !o_empty;

        //////////////////////////////
        // storage and pointers
        //////////////////////////////

        always_ff @(posedge i_rclk) begin
                if (do_wr) begin
                        mem[wr_ptr[`FPU_INQ_PTR_W-1:0]] <= i_tag;
                end
        end

        always_ff @(posedge i_rclk) begin
                if (!i_rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                end else begin
                        if (do_wr) begin
                                wr_ptr <= wr_ptr + 1'b1;
                        end
                        if (do_rd) begin
                                rd_ptr <= rd_ptr + 1'b1;
                        end
                end
        end

        // nothing is shown until a tag has been written
        assign o_head = o_empty ? '0 : mem[rd_ptr[`FPU_INQ_PTR_W-1:0]];

        // the source must hold off at the queue depth
        a_no_overflow: assert property (@(posedge i_rclk) disable iff (!i_rst_n)
                full |-> !i_we);

        // the issue stage only pops a tag it is showing
        a_no_underflow: assert property (@(posedge i_rclk) disable iff (!i_rst_n)
                o_empty |-> !i_pop);

endmodule

/* design/fpu_req_decode.sv */
/*
 * fpu request capture and decode
 * registers the incoming request, classifies it as add, multiply
 * or divide and produces a queue write with a one-hot pipe tag
 */

`timescale 1ns/1ps

`include "fpu_in_defines.svh"

module fpu_req_decode (
        input  logic                    i_rclk,
        input  logic                    i_rst_n,
        input  logic                    i_req_rdy,
        input  logic                    i_req_vld,
        input  fpu_in_pkg::req_type_t   i_req_type,
        input  fpu_in_pkg::fp_op_t      i_req_op,
        input  logic                    i_req_op7,
        output logic                    o_am_we,
        output logic                    o_div_we,
        output fpu_in_pkg::pipe_tag_t   o_tag
);

        import fpu_in_pkg::*;

        logic           req_rdy;        // only control bit of the capture stage
        logic           req_vld;
        req_type_t      req_type;
        fp_op_t         req_op;
        logic           req_op7;

        logic           accept;
        logic           is_add;
        logic           is_mul;
        logic           is_div;

        //////////////////////////////
        // capture
        //////////////////////////////

        always_ff @(posedge i_rclk) begin
                if (!i_rst_n) begin
                        req_rdy <= 1'b0;
                end else begin
                        req_rdy <= i_req_rdy;
                end
        end

        always_ff @(posedge i_rclk) begin
                req_vld  <= i_req_vld;
                req_type <= i_req_type;
                req_op   <= i_req_op;
                req_op7  <= i_req_op7;
        end

        //////////////////////////////
        // classify
        //////////////////////////////

        assign accept = req_rdy && req_vld;

        // op bit 3 clear on a second group op is an add
        assign is_add = accept && (((req_type == `FPU_TYPE_FPOP1) && req_op7) ||
                        ((req_type == `FPU_TYPE_FPOP2) && !req_op7 && !req_op[1]));
        assign is_mul = accept && (req_type == `FPU_TYPE_FPOP2) && !req_op7 &&
                        (req_op == `FPU_OP_MUL);
        assign is_div = accept && (req_type == `FPU_TYPE_FPOP2) && !req_op7 &&
                        (req_op == `FPU_OP_DIV);

        assign o_tag    = {is_div, is_mul, is_add};
        assign o_am_we  = is_add || is_mul;     // add and mul share a queue
        assign o_div_we = is_div;

        // a write always carries exactly one pipe and lands in one queue
        a_tag_onehot: assert property (@(posedge i_rclk) disable iff (!i_rst_n)
                (o_am_we || o_div_we) |-> ($onehot(o_tag) && !(o_am_we && o_div_we)));

endmodule

/* design/fpu_in_pkg.sv */
/*
 * fpu input control types
 * vector types shared by the decode, queue and issue stages
 */

`include "fpu_in_defines.svh"

package fpu_in_pkg;

        // packet type field of a request
        typedef logic [4:0] req_type_t;

        // opcode bits [3:2]
        typedef logic [1:0] fp_op_t;

        // one-hot pipe select
        // bit 2 divide, bit 1 multiply, bit 0 add
        typedef logic [2:0] pipe_tag_t;

        // queue pointer, msb is the wrap bit
        typedef logic [`FPU_INQ_PTR_W:0] inq_ptr_t;

endpackage

/* design/fpu_in_defines.svh */
/*
 * fpu input control constants
 * packet type codes, opcode codes and input queue sizing
 */

`ifndef FPU_IN_DEFINES_SVH
`define FPU_IN_DEFINES_SVH

//////////////////////////////
// packet types
//////////////////////////////

`define FPU_TYPE_FPOP1  5'h0a   // first group fp op
`define FPU_TYPE_FPOP2  5'h0b   // second group fp op

// opcode bits [3:2] of a second group op
`define FPU_OP_MUL      2'b10
`define FPU_OP_DIV      2'b11

//////////////////////////////
// input queues
//////////////////////////////

`define FPU_INQ_DEPTH   8       // entries per queue
`define FPU_INQ_PTR_W   3       // index width, pointers add a wrap bit

`endif
